/* dqmFramer.f */
+incdir+verilog
verilog/dqmPkg.sv
verilog/dqmFifo.sv
verilog/dqmPayloadBuffer.sv
verilog/dqmBitClock.sv
verilog/dqmFrameSerializer.sv
verilog/dqmFramerTop.sv
test/dqmFramerTb.sv

/* runSim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module dqmFramerTb \
    -f dqmFramer.f \
    -o simv

./obj_dir/simv > sim.log
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0

/* test/dqmFramerTb.sv */
`timescale 1ns/1ps
`include "dqmFramer_macros.svh"

module dqmFramerTb;

    localparam logic [3:0] tbVersion = 4'hA;
    localparam int blockBits = 32;
    localparam int frameBits = `DQM_HEADER_BITS + blockBits;
    // Slot every 4 clocks
    localparam logic [31:0] tbFreq = 32'h4000_0000;
    localparam int frameClocks = frameBits * 4;
    localparam int slowBlocks = 8;
    localparam int fastBlocks = 16;
    localparam int maxGap = 19;
    localparam int cycleLimit = (slowBlocks + fastBlocks + 2) * blockBits * maxGap
                                + 8 * frameClocks + 100;

    logic clk;
    logic reset;
    logic [15:0] dqm;
    logic [`DQM_SIZE_BITS-1:0] payloadSize;
    logic payloadBitEn;
    logic payloadBit;
    logic [31:0] centerFreq;
    logic dqmStartOfFrame;
    logic dqmBitEn;
    logic dqmBit;

    logic [31:0] lcgState = 32'd59;
    logic [31:0] modelPhase;
    logic modelSlot;
    logic fastRun;
    logic [31:0] curBlock;
    logic [31:0] blockQ[$];
    logic hist[$];
    logic [47:0] rxHeader;
    logic [31:0] rxPayload;
    int rxCount;
    int strobeIndex;
    int fillCount;
    int blocksDone;
    int framesDone;
    int quietCycles;
    int cycleCount = 0;
    int errorCount = 0;

    dqmFramerTop #(.VERSION(tbVersion)) i_dqmFramerTop (
        .clk(clk), .reset(reset), .dqm(dqm), .payloadSize(payloadSize),
        .payloadBitEn(payloadBitEn), .payloadBit(payloadBit),
        .centerFreq(centerFreq), .dqmStartOfFrame(dqmStartOfFrame),
        .dqmBitEn(dqmBitEn), .dqmBit(dqmBit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Block seen anywhere in the input history at any alignment
    function automatic bit inHistory(logic [31:0] payload);
        bit same;
        for (int s = 0; s + blockBits <= hist.size(); s++) begin
            same = 1'b1;
            for (int i = 0; i < blockBits; i++) begin
                if (hist[s + i] != payload[i]) same = 1'b0;
            end
            if (same) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Model accumulator with the same reset and increment as the DUT
    always @(posedge clk) begin
        logic [32:0] sum;
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Some tests failed");
            $finish;
        end else if (reset) begin
            modelPhase = '0;
            modelSlot = 1'b0;
        end else begin
            sum = {1'b0, modelPhase} + {1'b0, centerFreq};
            modelPhase = sum[31:0];
            modelSlot = sum[32];
        end
    end

    always @(negedge clk) begin
        logic [47:0] expHeader;
        logic [31:0] expBlock;
        logic expStart;
        if (!reset) begin
            if (payloadBitEn) begin
                expStart = (strobeIndex > 0) && (strobeIndex % blockBits == 0);
                if (!fastRun && (dqmStartOfFrame != expStart)) begin
                    errorCount++;
                    $display("** Error at %0t: dqmStartOfFrame expected %0b actual %0b",
                             $time, expStart, dqmStartOfFrame);
                end
                // First strobe after reset only leaves the flush state
                if (strobeIndex > 0) begin
                    curBlock[fillCount] = payloadBit;
                    hist.push_back(payloadBit);
                    fillCount++;
                    if (fillCount == blockBits) begin
                        blockQ.push_back(curBlock);
                        fillCount = 0;
                        blocksDone++;
                    end
                end
                strobeIndex++;
            end
            if (dqmBitEn) begin
                quietCycles = 0;
                if (!modelSlot) begin
                    errorCount++;
                    $display("** Error at %0t: dqmBitEn expected 0 actual 1", $time);
                end
                if (blocksDone == 0) begin
                    errorCount++;
                    $display("Output bit sent before the first block was complete at %0t", $time);
                end
                if (rxCount < `DQM_HEADER_BITS) rxHeader = {rxHeader[46:0], dqmBit};
                else rxPayload[rxCount - `DQM_HEADER_BITS] = dqmBit;
                rxCount++;
                if (rxCount == frameBits) begin
                    expHeader = {`DQM_SYNC_WORD, 12'h000, tbVersion, dqm};
                    if (rxHeader != expHeader) begin
                        errorCount++;
                        $display("** Error at %0t: dqmBit header expected %h actual %h",
                                 $time, expHeader, rxHeader);
                    end
                    if (fastRun) begin
                        if (!inHistory(rxPayload)) begin
                            errorCount++;
                            $display("Frame payload %h at %0t matches no input block",
                                     rxPayload, $time);
                        end
                    end else if (blockQ.size() == 0) begin
                        errorCount++;
                        $display("Frame at %0t has no completed block to carry", $time);
                    end else begin
                        expBlock = blockQ.pop_front();
                        if (rxPayload != expBlock) begin
                            errorCount++;
                            $display("** Error at %0t: dqmBit payload expected %h actual %h",
                                     $time, expBlock, rxPayload);
                        end
                    end
                    framesDone++;
                    rxCount = 0;
                end
            end else begin
                quietCycles++;
                // A slot with no output bit inside a frame means it was aborted
                if (modelSlot && rxCount > 0) begin
                    if (!fastRun) begin
                        errorCount++;
                        $display("Frame cut short after %0d bits at %0t", rxCount, $time);
                    end
                    rxCount = 0;
                end
            end
        end
    end

    task automatic startRun(input logic fast);
        reset <= 1'b1;
        payloadBitEn <= 1'b0;
        dqm <= 16'(nextRandom() >> 16);
        fastRun = fast;
        blockQ.delete();
        hist.delete();
        strobeIndex = 0;
        fillCount = 0;
        blocksDone = 0;
        framesDone = 0;
        rxCount = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
    endtask

    task automatic sendBits(input int count);
        int gap;
        logic fastBlock;
        fastBlock = 1'b0;
        for (int i = 0; i < count; i++) begin
            if (fastRun && (i % blockBits == 0)) fastBlock = 1'(nextRandom() >> 31);
            gap = fastBlock ? 1 + (nextRandom() >> 31) : 12 + (nextRandom() >> 29);
            payloadBit <= 1'(nextRandom() >> 31);
            payloadBitEn <= 1'b1;
            @(posedge clk);
            payloadBitEn <= 1'b0;
            repeat (gap - 1) @(posedge clk);
        end
    endtask

    task automatic waitQuiet();
        quietCycles = 0;
        while (quietCycles < 2 * frameClocks) @(posedge clk);
    endtask

    initial begin
        reset = 1'b1;
        dqm = '0;
        payloadSize = `DQM_SIZE_BITS'(blockBits - 1);
        payloadBitEn = 1'b0;
        payloadBit = 1'b0;
        centerFreq = tbFreq;
        fastRun = 1'b0;
        quietCycles = 0;

        // Slow input gives every block its own frame
        startRun(1'b0);
        sendBits(slowBlocks * blockBits + 1);
        while (framesDone < slowBlocks) @(posedge clk);
        waitQuiet();

        // Bursts that outrun the output
        startRun(1'b1);
        sendBits(fastBlocks * blockBits + 1);
        waitQuiet();
        if (framesDone == 0) begin
            errorCount++;
            $display("No complete frame was sent during the overrun run");
        end
        if (framesDone >= blocksDone) begin
            errorCount++;
            $display("Overrun run dropped no frames, so no overrun took place");
        end

        $display("Checks finished with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* verilog/dqmBitClock.sv */
`timescale 1ns/1ps
`include "dqmFramer_macros.svh"

module dqmBitClock (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`DQM_PHASE_BITS-1:0]  centerFreq,
    output logic                        bitSlot
);

    logic [`DQM_PHASE_BITS-1:0] phase;
    logic [`DQM_PHASE_BITS:0]   phaseSum;

    // MSB of the sum is the carry
    assign phaseSum = {1'b0, phase} + {1'b0, centerFreq};

    // One slot per wrap, so the mean rate is centerFreq / 2^32 of clk
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
            bitSlot <= 1'b0;
        end else begin
            phase <= phaseSum[`DQM_PHASE_BITS-1:0];
            bitSlot <= phaseSum[`DQM_PHASE_BITS];
        end
    end

endmodule

/* verilog/dqmFifo.sv */
`timescale 1ns/1ps
`include "dqmFramer_macros.svh"

module dqmFifo (
    input  logic clk,
    input  logic reset,
    input  logic din,
    input  logic writeEn,
    input  logic readEn,
    output logic dout,
    output logic empty
);

    localparam int addrBits = $clog2(`DQM_FIFO_DEPTH);

    logic               mem [0:`DQM_FIFO_DEPTH-1];
    // Extra MSB tells full from empty
    logic [addrBits:0]  writePtr;
    logic [addrBits:0]  readPtr;
    logic [addrBits:0]  readPtrNext;
    logic               full;
    logic               doWrite;
    logic               doRead;

    assign empty = (writePtr == readPtr);
    assign full = (writePtr[addrBits] != readPtr[addrBits]) &&
                  (writePtr[addrBits-1:0] == readPtr[addrBits-1:0]);
    assign doWrite = writeEn && !full;
    assign doRead = readEn && !empty;
    assign readPtrNext = readPtr + {{addrBits{1'b0}}, doRead};

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[writePtr[addrBits-1:0]] <= din;
        end
    end

    // dout always holds the head entry, bypassing a write into an empty slot
    always_ff @(posedge clk) begin
        if (doWrite && (writePtr[addrBits-1:0] == readPtrNext[addrBits-1:0])) begin
            dout <= din;
        end else begin
            dout <= mem[readPtrNext[addrBits-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            writePtr <= '0;
            readPtr <= '0;
        end else begin
            if (doWrite) begin
                writePtr <= writePtr + 1'b1;
            end
            readPtr <= readPtrNext;
        end
    end

endmodule

/* verilog/dqmFrameSerializer.sv */
`timescale 1ns/1ps
`include "dqmFramer_macros.svh"

module dqmFrameSerializer #(
    parameter logic [`DQM_VERSION_BITS-1:0] VERSION = 4'd0
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`DQM_WORD_BITS-1:0]   dqm,
    input  logic [`DQM_SIZE_BITS-1:0]   payloadSize,
    input  logic                        payloadBitEn,
    input  logic                        bitSlot,
    input  dqmPkg::dqmBufStatus_t       status,
    output dqmPkg::dqmReadReq_t         readReq,
    output logic                        dqmBitEn,
    output logic                        dqmBit
);

    localparam logic [1:0] stateIdle    = 2'd0;
    localparam logic [1:0] stateWait    = 2'd1;
    localparam logic [1:0] stateHeader  = 2'd2;
    localparam logic [1:0] statePayload = 2'd3;

    logic [1:0]                 state;
    logic [`DQM_SIZE_BITS-1:0]  shiftCount;
    dqmPkg::dqmHeader_t         header;

    function automatic dqmPkg::dqmHeader_t freshHeader(
        input logic [`DQM_WORD_BITS-1:0] dqmWord
    );
        dqmPkg::dqmHeader_t h;
        h.fields.sync = `DQM_SYNC_WORD;
        h.fields.reserved = '0;
        h.fields.version = VERSION;
        h.fields.dqm = dqmWord;
        return h;
    endfunction

    always_ff @(posedge clk) begin
        if (reset || status.flushing) begin
            state <= stateIdle;
            header <= freshHeader(dqm);
            readReq <= '0;
        end else begin
            case (state)
                stateIdle: begin
                    header <= freshHeader(dqm);
                    readReq <= '0;
                    if (payloadBitEn && status.frameStart) begin
                        shiftCount <= `DQM_SIZE_BITS'(`DQM_HEADER_BITS - 1);
                        state <= bitSlot ? stateHeader : stateWait;
                    end
                end
                // First header bit goes out on this slot
                stateWait: begin
                    if (bitSlot) begin
                        state <= stateHeader;
                        shiftCount <= shiftCount - 1'b1;
                        header.raw <= {header.raw[`DQM_HEADER_BITS-2:0], 1'b0};
                    end
                end
                stateHeader: begin
                    if (bitSlot) begin
                        if (shiftCount == '0) begin
                            state <= statePayload;
                            shiftCount <= payloadSize;
                            readReq.pingRead <= status.readSelect && !status.pingEmpty;
                            readReq.pongRead <= !status.readSelect && !status.pongEmpty;
                        end else begin
                            shiftCount <= shiftCount - 1'b1;
                            header.raw <= {header.raw[`DQM_HEADER_BITS-2:0], 1'b0};
                        end
                    end
                end
                statePayload: begin
                    if (bitSlot) begin
                        if (shiftCount == '0) begin
                            state <= stateIdle;
                            readReq <= '0;
                        end else begin
                            shiftCount <= shiftCount - 1'b1;
                        end
                    end
                end
                default: begin
                    state <= stateIdle;
                end
            endcase
        end
    end

    // Header MSB until the payload, then the head of the block's FIFO
    always_comb begin
        if (state == statePayload) begin
            dqmBit = status.readSelect ? status.pingBit : status.pongBit;
        end else begin
            dqmBit = header.raw[`DQM_HEADER_BITS-1];
        end
    end

    assign dqmBitEn = bitSlot && (state != stateIdle);

endmodule

/* verilog/dqmFramerTop.sv */
`timescale 1ns/1ps
`include "dqmFramer_macros.svh"

module dqmFramerTop #(
    parameter logic [`DQM_VERSION_BITS-1:0] VERSION = 4'd0
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`DQM_WORD_BITS-1:0]   dqm,
    input  logic [`DQM_SIZE_BITS-1:0]   payloadSize,
    input  logic                        payloadBitEn,
    input  logic                        payloadBit,
    input  logic [`DQM_PHASE_BITS-1:0]  centerFreq,
    output logic                        dqmStartOfFrame,
    output logic                        dqmBitEn,
    output logic                        dqmBit
);

    dqmPkg::dqmBufStatus_t  bufStatus;
    dqmPkg::dqmReadReq_t    readReq;
    logic                   bitSlot;

    dqmPayloadBuffer i_dqmPayloadBuffer (
        .clk(clk),
        .reset(reset),
        .payloadSize(payloadSize),
        .payloadBitEn(payloadBitEn),
        .payloadBit(payloadBit),
        .bitSlot(bitSlot),
        .readReq(readReq),
        .status(bufStatus)
    );

    dqmBitClock i_dqmBitClock (
        .clk(clk),
        .reset(reset),
        .centerFreq(centerFreq),
        .bitSlot(bitSlot)
    );

    dqmFrameSerializer #(
        .VERSION(VERSION)
    ) i_dqmFrameSerializer (
        .clk(clk),
        .reset(reset),
        .dqm(dqm),
        .payloadSize(payloadSize),
        .payloadBitEn(payloadBitEn),
        .bitSlot(bitSlot),
        .status(bufStatus),
        .readReq(readReq),
        .dqmBitEn(dqmBitEn),
        .dqmBit(dqmBit)
    );

    assign dqmStartOfFrame = bufStatus.frameStart;

endmodule

/* verilog/dqmFramer_macros.svh */
`ifndef DQM_FRAMER_MACROS_SVH
`define DQM_FRAMER_MACROS_SVH

// Frame sync pattern, first on the wire
`define DQM_SYNC_WORD       16'hEB90

// Header layout, MSB first: sync, reserved zeros, version, dqm
`define DQM_HEADER_BITS     48
`define DQM_WORD_BITS       16
`define DQM_RESERVED_BITS   12
`define DQM_VERSION_BITS    4

// Block length field and NCO accumulator
`define DQM_SIZE_BITS       14
`define DQM_PHASE_BITS      32

// One largest block per FIFO
`define DQM_FIFO_DEPTH      16384

`endif

/* verilog/dqmPayloadBuffer.sv */
`timescale 1ns/1ps
`include "dqmFramer_macros.svh"

module dqmPayloadBuffer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`DQM_SIZE_BITS-1:0]   payloadSize,
    input  logic                        payloadBitEn,
    input  logic                        payloadBit,
    input  logic                        bitSlot,
    input  dqmPkg::dqmReadReq_t         readReq,
    output dqmPkg::dqmBufStatus_t       status
);

    localparam logic stateFlush = 1'b0;
    localparam logic stateWrite = 1'b1;

    logic                       state;
    logic [`DQM_SIZE_BITS-1:0]  bitCount;
    logic                       writePing;
    logic                       readPing;
    logic                       frameStart;
    logic                       pingWrite;
    logic                       pongWrite;
    logic                       pingPop;
    logic                       pongPop;
    logic                       pingEmpty;
    logic                       pongEmpty;
    logic                       pingBit;
    logic                       pongBit;

    assign frameStart = (bitCount == '0);

    assign pingWrite = payloadBitEn && (state == stateWrite) && writePing;
    assign pongWrite = payloadBitEn && (state == stateWrite) && !writePing;

    // Flush drains both FIFOs every clock, otherwise reads follow the bit slots
    assign pingPop = (state == stateFlush) || (readReq.pingRead && bitSlot);
    assign pongPop = (state == stateFlush) || (readReq.pongRead && bitSlot);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stateFlush;
            bitCount <= `DQM_SIZE_BITS'(1);
            writePing <= 1'b1;
            readPing <= 1'b0;
        end else if (payloadBitEn) begin
            case (state)
                stateFlush: begin
                    if (pingEmpty && pongEmpty) begin
                        state <= stateWrite;
                        bitCount <= payloadSize;
                        writePing <= 1'b1;
                    end
                end
                stateWrite: begin
                    if (frameStart) begin
                        bitCount <= payloadSize;
                        writePing <= !writePing;
                        readPing <= writePing;
                        // Next target still holds an undrained block
                        if (writePing ? !pongEmpty : !pingEmpty) begin
                            state <= stateFlush;
                        end
                    end else begin
                        bitCount <= bitCount - 1'b1;
                    end
                end
                default: begin
                    state <= stateFlush;
                end
            endcase
        end
    end

    dqmFifo pingFifo (
        .clk(clk),
        .reset(reset),
        .din(payloadBit),
        .writeEn(pingWrite),
        .readEn(pingPop),
        .dout(pingBit),
        .empty(pingEmpty)
    );

    dqmFifo pongFifo (
        .clk(clk),
        .reset(reset),
        .din(payloadBit),
        .writeEn(pongWrite),
        .readEn(pongPop),
        .dout(pongBit),
        .empty(pongEmpty)
    );

    assign status.frameStart = frameStart;
    assign status.flushing = (state == stateFlush);
    assign status.readSelect = readPing;
    assign status.pingEmpty = pingEmpty;
    assign status.pongEmpty = pongEmpty;
    assign status.pingBit = pingBit;
    assign status.pongBit = pongBit;

endmodule

/* verilog/dqmPkg.sv */
`include "dqmFramer_macros.svh"

package dqmPkg;

    // Header word, built field by field and shifted out as a whole
    typedef union packed {
        struct packed {
            logic [`DQM_WORD_BITS-1:0]      sync;
            logic [`DQM_RESERVED_BITS-1:0]  reserved;
            logic [`DQM_VERSION_BITS-1:0]   version;
            logic [`DQM_WORD_BITS-1:0]      dqm;
        } fields;
        logic [`DQM_HEADER_BITS-1:0] raw;
    } dqmHeader_t;

    // Payload buffer to serializer
    typedef struct packed {
        // Block counter at zero
        logic frameStart;
        logic flushing;
        // High selects the ping FIFO
        logic readSelect;
        logic pingEmpty;
        logic pongEmpty;
        // Head of each FIFO
        logic pingBit;
        logic pongBit;
    } dqmBufStatus_t;

    // Serializer to payload buffer, levels qualified by bitSlot in the buffer
    typedef struct packed {
        logic pingRead;
        logic pongRead;
    } dqmReadReq_t;

endpackage
